// ==== source/gpio_bus_pkg.sv ====
`default_nettype none

package gpio_bus_pkg;

    // Bus word and register address sizes
    localparam int unsigned data_width = 16;
    localparam int unsigned addr_width = 4;

    // One data word on the bus
    typedef logic [data_width-1:0] bus_data_t;

    // Register index, sixteen slots
    typedef logic [addr_width-1:0] bus_addr_t;

    // Request from the master
    // Plain strobes, sampled on every rising edge
    typedef struct packed {
        logic      wr;
        logic      rd;
        bus_addr_t addr;
        bus_data_t wdata;
    } bus_req_t;

    // Response back to the master
    // rd_valid pulses one cycle after rd
    typedef struct packed {
        logic      rd_valid;
        bus_data_t rdata;
    } bus_rsp_t;

    // Register map
    localparam bus_addr_t addr_leds      = 4'd0;
    localparam bus_addr_t addr_digits_lo = 4'd1;
    // Digits 4 and 5 in the low byte
    localparam bus_addr_t addr_digits_hi = 4'd2;
    // One blanking bit per display
    localparam bus_addr_t addr_blank     = 4'd3;

endpackage

`default_nettype wire

// ==== source/display_pkg.sv ====
`default_nettype none

package display_pkg;

    // Six static displays on the board
    localparam int unsigned num_digits      = 6;
    localparam int unsigned digit_width     = 4;
    // Nibbles held in one digit register word
    localparam int unsigned digits_per_word = 4;

    // One hex digit
    typedef logic [digit_width-1:0] digit_t;

    // Segment a in bit 0, segment g in bit 6
    // A 1 lights the segment before polarity is applied
    typedef logic [6:0] segments_t;

    // All segments unlit, before polarity
    localparam segments_t seg_blank = 7'b000_0000;

    // Digit register word, seen as a bus word or as four nibbles
    typedef union packed {
        logic [digits_per_word*digit_width-1:0] raw;
        digit_t [digits_per_word-1:0]           nib;
    } digit_word_u;

    // Everything the display path needs
    typedef struct packed {
        digit_word_u           lo;
        digit_t                hi4;
        digit_t                hi5;
        logic [num_digits-1:0] blank;
    } digits_t;

    // Segment lines for all displays
    typedef segments_t [num_digits-1:0] seg_bus_t;

endpackage

`default_nettype wire

// ==== source/seven_display.sv ====
`timescale 1ns/1ps
`default_nettype none

module seven_display #(
    parameter bit INVERT = 1'b1
) (
    input  display_pkg::digit_t    n,
    output display_pkg::segments_t segments
);

    // Active-high pattern straight from the table
    display_pkg::segments_t lit;

    // Hex to segments, bit order gfedcba
    always_comb begin
        case (n)
            4'h0: lit = 7'b0111111;
            4'h1: lit = 7'b0000110;
            4'h2: lit = 7'b1011011;
            4'h3: lit = 7'b1001111;
            4'h4: lit = 7'b1100110;
            4'h5: lit = 7'b1101101;
            4'h6: lit = 7'b1111101;
            4'h7: lit = 7'b0000111;
            4'h8: lit = 7'b1111111;
            4'h9: lit = 7'b1100111;
            // Letters, b and d in lower case
            4'hA: lit = 7'b1110111;
            4'hB: lit = 7'b1111100;
            4'hC: lit = 7'b0111001;
            4'hD: lit = 7'b1011110;
            4'hE: lit = 7'b1111001;
            4'hF: lit = 7'b1110001;
            default: lit = display_pkg::seg_blank;
        endcase
    end

    // Common-anode parts want active-low lines
    assign segments = INVERT ? ~lit : lit;

endmodule

`default_nettype wire

// ==== source/display_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module display_bank #(
    parameter bit INVERT = 1'b1
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  display_pkg::digits_t  digits,
    output display_pkg::seg_bus_t segs
);

    // Dark pattern after polarity
    localparam display_pkg::segments_t seg_dark =
        INVERT ? ~display_pkg::seg_blank : display_pkg::seg_blank;

    // One digit per display
    display_pkg::digit_t [display_pkg::num_digits-1:0] digit_n;

    // Decoder outputs and blanked next state
    display_pkg::seg_bus_t seg_dec;
    display_pkg::seg_bus_t seg_d;
    display_pkg::seg_bus_t seg_q;

    // Digits 0 to 3 come from the union nibbles
    // Digits 4 and 5 from the high fields
    always_comb begin
        for (int i = 0; i < display_pkg::digits_per_word; i++) begin
            digit_n[i] = digits.lo.nib[i];
        end
        digit_n[4] = digits.hi4;
        digit_n[5] = digits.hi5;
    end

    // Per-display decode and blanking
    for (genvar g = 0; g < display_pkg::num_digits; g++) begin : g_digit
        seven_display #(
            .INVERT   (INVERT)
        ) u_seven_display (
            .n        (digit_n[g]),
            .segments (seg_dec[g])
        );

        // Blank bit wins over the decoded digit
        assign seg_d[g] = digits.blank[g] ? seg_dark : seg_dec[g];
    end

    // Output stage, one cycle behind the registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // Displays stay dark while in reset
            seg_q <= {display_pkg::num_digits{seg_dark}};
        end else begin
            seg_q <= seg_d;
        end
    end

    assign segs = seg_q;

endmodule

`default_nettype wire

// ==== source/gpio_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpio_regs (
    input  logic                   clk,
    input  logic                   rst_n,
    input  gpio_bus_pkg::bus_req_t req,
    output gpio_bus_pkg::bus_rsp_t rsp,
    output logic [7:0]             leds,
    output display_pkg::digits_t   digits
);

    // Register 0, LED bits
    logic [7:0] leds_q;

    // Register 1, digits 0 to 3
    display_pkg::digit_word_u lo_q;

    // Register 2, digits 4 and 5
    display_pkg::digit_t hi4_q;
    display_pkg::digit_t hi5_q;

    // Register 3, blanking mask
    logic [display_pkg::num_digits-1:0] blank_q;

    // Read mux and response register
    gpio_bus_pkg::bus_data_t rdata_d;
    gpio_bus_pkg::bus_rsp_t  rsp_q;

    // Write decode
    // Each register keeps only its own bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            leds_q  <= '0;
            lo_q    <= '0;
            hi4_q   <= '0;
            hi5_q   <= '0;
            blank_q <= '0;
        end else if (req.wr) begin
            case (req.addr)
                gpio_bus_pkg::addr_leds: begin
                    leds_q <= req.wdata[7:0];
                end
                gpio_bus_pkg::addr_digits_lo: begin
                    // Full word, four nibbles
                    lo_q.raw <= req.wdata;
                end
                gpio_bus_pkg::addr_digits_hi: begin
                    // High byte dropped
                    hi4_q <= req.wdata[3:0];
                    hi5_q <= req.wdata[7:4];
                end
                gpio_bus_pkg::addr_blank: begin
                    blank_q <= req.wdata[display_pkg::num_digits-1:0];
                end
                default: begin
                    // Unmapped slot, write dropped
                end
            endcase
        end
    end

    // Read mux on current contents
    // Same-cycle write is not yet visible here, so reads see the old value
    always_comb begin
        rdata_d = '0;
        case (req.addr)
            gpio_bus_pkg::addr_leds: begin
                rdata_d = {{(gpio_bus_pkg::data_width-8){1'b0}}, leds_q};
            end
            gpio_bus_pkg::addr_digits_lo: begin
                rdata_d = lo_q.raw;
            end
            gpio_bus_pkg::addr_digits_hi: begin
                // Unused high byte reads zero
                rdata_d = {{(gpio_bus_pkg::data_width-8){1'b0}}, hi5_q, hi4_q};
            end
            gpio_bus_pkg::addr_blank: begin
                rdata_d = {{(gpio_bus_pkg::data_width-display_pkg::num_digits){1'b0}},
                           blank_q};
            end
            default: begin
                // Unmapped reads zero
                rdata_d = '0;
            end
        endcase
    end

    // Response stage
    // rd_valid follows rd by one edge, data loads only on a read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_q <= '0;
        end else begin
            rsp_q.rd_valid <= req.rd;
            if (req.rd) begin
                rsp_q.rdata <= rdata_d;
            end
        end
    end

    assign rsp  = rsp_q;
    assign leds = leds_q;

    // Display state for the bank
    always_comb begin
        digits.lo    = lo_q;
        digits.hi4   = hi4_q;
        digits.hi5   = hi5_q;
        digits.blank = blank_q;
    end

endmodule

`default_nettype wire

// ==== source/gpio_display_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpio_display_top #(
    // 1 for active-low segment lines
    parameter bit INVERT = 1'b1
) (
    input  logic                   clk,
    input  logic                   rst_n,
    // Register bus from the master
    input  gpio_bus_pkg::bus_req_t req,
    output gpio_bus_pkg::bus_rsp_t rsp,
    // Board pins
    output logic [7:0]             leds,
    output display_pkg::seg_bus_t  segs
);

    // Display state from the register file
    display_pkg::digits_t digits;

    // Register file
    // LEDs one cycle after a write, reads one cycle after rd
    gpio_regs u_gpio_regs (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (req),
        .rsp    (rsp),
        .leds   (leds),
        .digits (digits)
    );

    // Decode, blank and register the six displays
    // Adds one more cycle on the segment path
    display_bank #(
        .INVERT (INVERT)
    ) u_display_bank (
        .clk    (clk),
        .rst_n  (rst_n),
        .digits (digits),
        .segs   (segs)
    );

endmodule

`default_nettype wire

// ==== verification/gpio_display_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpio_display_checker (
    input logic                   clk,
    input logic                   rst_n,
    input gpio_bus_pkg::bus_req_t req,
    input gpio_bus_pkg::bus_rsp_t rsp
);

    // Failed assertions, summed into the testbench totals
    int unsigned fail_count = 0;

    // rd_valid is rd delayed by one edge
    // Skipped on the first edge out of reset
    a_rd_follows: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> (rsp.rd_valid == $past(req.rd)))
    else begin
        fail_count++;
        $error("rd_valid does not match rd of the previous cycle");
    end

    // No response while held in reset
    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !rsp.rd_valid)
    else begin
        fail_count++;
        $error("rd_valid is high during reset");
    end

    // Two valid cycles in a row need two reads in a row
    a_no_stray_pair: assert property (@(posedge clk) disable iff (!rst_n)
        (rsp.rd_valid && $past(rsp.rd_valid)) |-> ($past(req.rd) && $past(req.rd, 2)))
    else begin
        fail_count++;
        $error("rd_valid held two cycles without two reads before it");
    end

endmodule

// Attached to every register file instance
bind gpio_regs gpio_display_checker u_gpio_display_checker (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .rsp   (rsp)
);

`default_nettype wire

// ==== verification/gpio_display_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpio_display_tb;

    // DUT polarity, active-low segments
    localparam bit          invert        = 1'b1;
    localparam int unsigned random_cycles = 2000;
    localparam int unsigned reset_timeout = 20;

    logic                   clk;
    logic                   rst_n;
    gpio_bus_pkg::bus_req_t req;
    gpio_bus_pkg::bus_rsp_t rsp;
    logic [7:0]             leds;
    display_pkg::seg_bus_t  segs;

    // Shadow registers
    logic [7:0]                         m_leds;
    display_pkg::digit_word_u           m_lo;
    display_pkg::digit_t                m_hi4;
    display_pkg::digit_t                m_hi5;
    logic [display_pkg::num_digits-1:0] m_blank;

    // Expected registered outputs
    gpio_bus_pkg::bus_rsp_t exp_rsp;
    display_pkg::seg_bus_t  exp_segs;

    int unsigned cycle;
    int unsigned rsp_errors;
    int unsigned led_errors;
    int unsigned seg_errors;
    int unsigned assert_errors;
    bit          reset_ok;

    gpio_display_top #(
        .INVERT (invert)
    ) u_gpio_display_top (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (req),
        .rsp    (rsp),
        .leds   (leds),
        .segs   (segs)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Reset for five rising edges
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
    end

    // Lit segments per hex digit, bit 0 is segment a
    function automatic display_pkg::segments_t lit_pattern(input display_pkg::digit_t d);
        case (d)
            4'h0: return 7'h3F;
            4'h1: return 7'h06;
            4'h2: return 7'h5B;
            4'h3: return 7'h4F;
            4'h4: return 7'h66;
            4'h5: return 7'h6D;
            4'h6: return 7'h7D;
            4'h7: return 7'h07;
            4'h8: return 7'h7F;
            4'h9: return 7'h67;
            4'hA: return 7'h77;
            4'hB: return 7'h7C;
            4'hC: return 7'h39;
            4'hD: return 7'h5E;
            4'hE: return 7'h79;
            default: return 7'h71;
        endcase
    endfunction

    function automatic display_pkg::segments_t pin_level(input display_pkg::segments_t s);
        return invert ? ~s : s;
    endfunction

    // What the displays should show for the current shadow state
    function automatic display_pkg::seg_bus_t shadow_display();
        display_pkg::seg_bus_t s;
        display_pkg::digit_t   d;
        for (int i = 0; i < display_pkg::num_digits; i++) begin
            if (i < 4)
                d = m_lo.nib[i];
            else if (i == 4)
                d = m_hi4;
            else
                d = m_hi5;
            // Blanked means every segment unlit
            s[i] = m_blank[i] ? pin_level(7'h00) : pin_level(lit_pattern(d));
        end
        return s;
    endfunction

    // Register read-back, unused bits zero
    function automatic gpio_bus_pkg::bus_data_t read_shadow(input gpio_bus_pkg::bus_addr_t a);
        gpio_bus_pkg::bus_data_t v;
        v = '0;
        case (a)
            gpio_bus_pkg::addr_leds:      v[7:0] = m_leds;
            gpio_bus_pkg::addr_digits_lo: v = m_lo.raw;
            gpio_bus_pkg::addr_digits_hi: v[7:0] = {m_hi5, m_hi4};
            gpio_bus_pkg::addr_blank:     v[display_pkg::num_digits-1:0] = m_blank;
            default:                      v = '0;
        endcase
        return v;
    endfunction

    // One rising edge of the model
    // Reads and the segment stage both see the state before this edge's write
    task automatic advance_model(input gpio_bus_pkg::bus_req_t r);
        exp_segs = shadow_display();
        exp_rsp.rd_valid = r.rd;
        if (r.rd) begin
            exp_rsp.rdata = read_shadow(r.addr);
        end
        if (r.wr) begin
            case (r.addr)
                gpio_bus_pkg::addr_leds:      m_leds = r.wdata[7:0];
                gpio_bus_pkg::addr_digits_lo: m_lo.raw = r.wdata;
                gpio_bus_pkg::addr_digits_hi: {m_hi5, m_hi4} = r.wdata[7:0];
                gpio_bus_pkg::addr_blank:     m_blank = r.wdata[display_pkg::num_digits-1:0];
                default:                      ;
            endcase
        end
    endtask

    task automatic check_rsp(input gpio_bus_pkg::bus_rsp_t got,
                             input gpio_bus_pkg::bus_rsp_t exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t: %s response valid=%0b data=%h, expected valid=%0b data=%h",
                     $time, what, got.rd_valid, got.rdata, exp.rd_valid, exp.rdata);
            rsp_errors++;
        end
    endtask

    task automatic check_leds(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t: %s leds %h, expected %h", $time, what, got, exp);
            led_errors++;
        end
    endtask

    task automatic check_segs(input display_pkg::seg_bus_t got,
                              input display_pkg::seg_bus_t exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t: %s segments %h, expected %h", $time, what, got, exp);
            seg_errors++;
        end
    endtask

    // Drive one request, let one edge pass, compare everything
    task automatic bus_cycle(input logic wr, input logic rd,
                             input gpio_bus_pkg::bus_addr_t addr,
                             input gpio_bus_pkg::bus_data_t wdata);
        string what;
        req.wr    = wr;
        req.rd    = rd;
        req.addr  = addr;
        req.wdata = wdata;
        @(posedge clk);
        #2;
        cycle++;
        what = $sformatf("cycle %0d", cycle);
        advance_model(req);
        check_rsp(rsp, exp_rsp, what);
        check_leds(leds, m_leds, what);
        check_segs(segs, exp_segs, what);
    endtask

    task automatic wait_reset_release(input int unsigned max_cycles, output bit ok);
        int unsigned n;
        n = 0;
        while (rst_n !== 1'b1 && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        ok = (rst_n === 1'b1);
        if (!ok) begin
            $display("Timeout: reset still asserted after %0d cycles", max_cycles);
        end
    endtask

    initial begin
        logic                    r_wr;
        logic                    r_rd;
        gpio_bus_pkg::bus_addr_t r_addr;
        gpio_bus_pkg::bus_data_t r_data;
        req        = '0;
        m_leds     = '0;
        m_lo       = '0;
        m_hi4      = '0;
        m_hi5      = '0;
        m_blank    = '0;
        exp_rsp    = '0;
        cycle      = 0;
        rsp_errors = 0;
        led_errors = 0;
        seg_errors = 0;
        void'($urandom(32'hbc40_f019));
        wait_reset_release(reset_timeout, reset_ok);
        if (reset_ok) begin
            // Reset state before the first active edge, displays dark
            exp_segs = {display_pkg::num_digits{pin_level(7'h00)}};
            check_rsp(rsp, '0, "reset");
            check_leds(leds, 8'h00, "reset");
            check_segs(segs, exp_segs, "reset");
            // Idle edge, all six show digit 0
            bus_cycle(1'b0, 1'b0, 4'd0, 16'h0000);
            // LED write then read back, high bits dropped
            bus_cycle(1'b1, 1'b0, gpio_bus_pkg::addr_leds, 16'h12A5);
            bus_cycle(1'b0, 1'b1, gpio_bus_pkg::addr_leds, 16'h0000);
            // Digit words, high byte of register 2 dropped
            bus_cycle(1'b1, 1'b0, gpio_bus_pkg::addr_digits_lo, 16'h3C9F);
            bus_cycle(1'b1, 1'b0, gpio_bus_pkg::addr_digits_hi, 16'hBE7D);
            bus_cycle(1'b0, 1'b1, gpio_bus_pkg::addr_digits_hi, 16'h0000);
            bus_cycle(1'b0, 1'b1, gpio_bus_pkg::addr_digits_lo, 16'h0000);
            // Blank three displays, then restore them
            bus_cycle(1'b1, 1'b0, gpio_bus_pkg::addr_blank, 16'hFFE5);
            bus_cycle(1'b0, 1'b1, gpio_bus_pkg::addr_blank, 16'h0000);
            bus_cycle(1'b0, 1'b0, 4'd0, 16'h0000);
            bus_cycle(1'b1, 1'b0, gpio_bus_pkg::addr_blank, 16'h0000);
            bus_cycle(1'b0, 1'b0, 4'd0, 16'h0000);
            bus_cycle(1'b0, 1'b0, 4'd0, 16'h0000);
            // Unmapped slots
            bus_cycle(1'b1, 1'b0, 4'd4, 16'hFFFF);
            bus_cycle(1'b0, 1'b1, 4'd4, 16'h0000);
            bus_cycle(1'b1, 1'b1, 4'd5, 16'hFFFF);
            bus_cycle(1'b0, 1'b1, gpio_bus_pkg::addr_leds, 16'h0000);
            // Read and write together, old value first
            bus_cycle(1'b1, 1'b1, gpio_bus_pkg::addr_leds, 16'h0033);
            bus_cycle(1'b0, 1'b1, gpio_bus_pkg::addr_leds, 16'h0000);
            // Random traffic over mapped and unmapped slots
            for (int n = 0; n < random_cycles; n++) begin
                r_wr   = $urandom % 2;
                r_rd   = $urandom % 2;
                r_addr = $urandom % 6;
                r_data = $urandom;
                bus_cycle(r_wr, r_rd, r_addr, r_data);
            end
        end
        assert_errors = u_gpio_display_top.u_gpio_regs.u_gpio_display_checker.fail_count;
        $display("Errors: response %0d, leds %0d, segments %0d, assertions %0d",
                 rsp_errors, led_errors, seg_errors, assert_errors);
        if (reset_ok && rsp_errors + led_errors + seg_errors + assert_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
source/gpio_bus_pkg.sv
source/display_pkg.sv
source/seven_display.sv
source/display_bank.sv
source/gpio_regs.sv
source/gpio_display_top.sv
verification/gpio_display_checker.sv
verification/gpio_display_tb.sv

// ==== Bender.yml ====
package:
  name: gpio_display

sources:
  - files:
      - source/gpio_bus_pkg.sv
      - source/display_pkg.sv
      - source/seven_display.sv
      - source/display_bank.sv
      - source/gpio_regs.sv
      - source/gpio_display_top.sv
  - target: test
    files:
      - verification/gpio_display_checker.sv
      - verification/gpio_display_tb.sv
